// File: src.f
rtl/i2si_pkg.sv
rtl/i2si_pin_sync.sv
rtl/i2si_deserializer.sv
rtl/i2si_frame_fifo.sv
rtl/i2si_rx_top.sv
verif/i2s_source.sv
verif/i2si_rx_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = i2si_rx_tb
FILELIST = src.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with $(TOOL), result checked in $(LOG)"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "All tests passed!" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: verif/i2si_rx_tb.sv
module i2si_rx_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import i2si_pkg::*;

    localparam int FIFO_DEPTH = 4;
    localparam int WAIT_LIMIT = 4000;                   // clk cycles, over ten frames on the wire
    localparam int SEED       = 32'hd2ff4d6b;

    logic          clk;
    logic          rst_n;
    logic          i2si_en;
    logic          sck;
    logic          ws;
    logic          sd;
    logic          frame_rd;
    logic          frame_valid;
    stereo_frame_t frame;
    logic          overflow;

    stereo_frame_t send_q[$];                           // frames for the source
    stereo_frame_t exp_q[$];                            // frames the DUT should deliver
    int            gap_q[$];                            // idle cycles before each read
    logic          send_done;
    int            errors;
    int            tests_run;
    int            tests_failed;

    always #4 clk = ~clk;

    i2si_rx_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i2si_rx_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .i2si_en     (i2si_en),
        .sck         (sck),
        .ws          (ws),
        .sd          (sd),
        .frame_rd    (frame_rd),
        .frame_valid (frame_valid),
        .frame       (frame),
        .overflow    (overflow)
    );

    i2s_source i2s_source_inst (
        .clk (clk),
        .sck (sck),
        .ws  (ws),
        .sd  (sd)
    );

    task automatic check_bit(input string name, input logic want, input logic got);
        assert (got === want)
        else
        begin
            $display("MISMATCH %s: expected %b actual %b", name, want, got);
            errors++;
        end
    endtask

    task automatic make_frames(input int n);
        stereo_frame_t f;
        send_q.delete();
        repeat (n)
        begin
            f.left  = 16'($urandom);
            f.right = 16'($urandom);
            send_q.push_back(f);
        end
    endtask

    // only the first keep frames survive when the FIFO fills without reads
    task automatic queue_expected(input int keep);
        for (int k = 0; k < keep && k < send_q.size(); k++)
            exp_q.push_back(send_q[k]);
    endtask

    task automatic set_gaps(input int n, input int max_gap);
        gap_q.delete();
        repeat (n)
            gap_q.push_back($urandom_range(max_gap, 0));
    endtask

    task automatic restart_rx();
        i2si_en = 1'b0;                                 // drops alignment
        repeat (4) @(negedge clk);
        i2si_en = 1'b1;
        repeat (2) @(negedge clk);
    endtask

    // wait for a head frame, compare it with the model, then pop it
    task automatic read_frame(input string name);
        stereo_frame_t want;
        int            cycles;
        cycles = 0;
        while (!frame_valid && cycles < WAIT_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        assert (frame_valid)
        else
        begin
            $display("%s: no frame arrived within %0d clk cycles", name, WAIT_LIMIT);
            errors++;
        end
        if (frame_valid)
        begin
            want = exp_q.pop_front();
            assert (frame === want)
            else
            begin
                $display("MISMATCH %s: expected %h actual %h", name, want, frame);
                errors++;
            end
            frame_rd = 1'b1;
            @(negedge clk);
            frame_rd = 1'b0;
        end
    endtask

    task automatic stream_frames(input string name);
        int n;
        n = send_q.size();
        fork
            i2s_source_inst.send_frames(send_q);
            begin
                for (int k = 0; k < n; k++)
                begin
                    repeat (gap_q[k]) @(negedge clk);
                    read_frame(name);
                end
            end
        join
    endtask

    // frame_valid has to stay low until the source is done
    task automatic watch_idle(input string name);
        int cycles;
        cycles = 0;
        while (!send_done && cycles < WAIT_LIMIT)
        begin
            check_bit(name, 1'b0, frame_valid);
            @(negedge clk);
            cycles++;
        end
        assert (send_done)
        else
        begin
            $display("%s: source still sending after %0d clk cycles", name, WAIT_LIMIT);
            errors++;
        end
    endtask

    task automatic close_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before)
            $display("test %s: pass", name);
        else
        begin
            tests_failed++;
            $display("test %s: FAIL with %0d errors", name, errors - errors_before);
        end
    endtask

    initial
    begin
        int mark;
        void'($urandom(SEED));
        clk          = 1'b0;
        rst_n        = 1'b0;
        i2si_en      = 1'b0;
        frame_rd     = 1'b0;
        send_done    = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;

        mark = errors;
        repeat (4) @(negedge clk);
        check_bit("reset_state", 1'b0, frame_valid);
        check_bit("reset_state", 1'b0, overflow);
        repeat (4) @(negedge clk);
        rst_n = 1'b1;                                   // after 8 cycles
        repeat (4) @(negedge clk);
        check_bit("reset_state", 1'b0, frame_valid);
        check_bit("reset_state", 1'b0, overflow);
        close_test("reset_state", mark);

        mark = errors;
        restart_rx();
        make_frames(17);
        send_q.push_front({16'hFFFF, 16'h0001});        // bit order and field swap
        send_q.push_front({16'h0001, 16'hAAAA});
        send_q.push_front({16'hAAAA, 16'hFFFF});
        queue_expected(send_q.size());
        set_gaps(send_q.size(), 0);
        stream_frames("in_order");
        close_test("in_order", mark);

        mark = errors;
        restart_rx();
        make_frames(30);
        queue_expected(30);
        set_gaps(30, 300);                              // a frame takes 320 cycles
        stream_frames("read_pacing");
        check_bit("read_pacing", 1'b0, overflow);
        close_test("read_pacing", mark);

        mark = errors;
        restart_rx();
        make_frames(7);
        queue_expected(FIFO_DEPTH);
        i2s_source_inst.send_frames(send_q);
        repeat (10) @(negedge clk);                     // last write attempt reaches the FIFO
        check_bit("overflow", 1'b1, overflow);
        repeat (FIFO_DEPTH) read_frame("overflow");
        check_bit("overflow", 1'b0, frame_valid);
        close_test("overflow", mark);

        mark = errors;
        make_frames(3);                                 // cut off, none expected
        send_done = 1'b0;
        fork
            begin
                i2s_source_inst.send_frames(send_q);
                send_done = 1'b1;
            end
            begin
                repeat (100) @(negedge clk);            // partway through a word
                i2si_en = 1'b0;
                repeat (2) @(negedge clk);
                check_bit("disable_realign", 1'b0, overflow);
                watch_idle("disable_realign");
            end
        join
        repeat (4) @(negedge clk);
        i2si_en = 1'b1;
        repeat (2) @(negedge clk);
        make_frames(4);
        queue_expected(4);
        set_gaps(4, 0);
        stream_frames("disable_realign");
        check_bit("disable_realign", 1'b0, frame_valid);
        close_test("disable_realign", mark);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// File: verif/i2s_source.sv
module i2s_source (
    input  logic clk,
    output logic sck,
    output logic ws,
    output logic sd
);

    timeunit 1ns;
    timeprecision 1ps;

    import i2si_pkg::*;

    localparam int HALF_CYCLES = 5;                     // clk cycles per sck phase

    initial
    begin
        sck = 1'b1;                                     // idle high
        ws  = 1'b0;
        sd  = 1'b0;
    end

    // ws and sd move with the falling edge, the receiver samples on the rising edge
    task automatic drive_bit(input ws_chan_t chan, input logic bit_val);
        sck = 1'b0;
        ws  = chan;
        sd  = bit_val;
        repeat (HALF_CYCLES) @(negedge clk);
        sck = 1'b1;
        repeat (HALF_CYCLES) @(negedge clk);
    endtask

    // ws already carries the next channel during the LSB
    task automatic send_word(input sample_t word, input ws_chan_t chan, input ws_chan_t next_chan);
        sample_t bits;
        bits = word;
        for (int i = SAMPLE_W - 1; i >= 0; i--)
        begin
            drive_bit((i == 0) ? next_chan : chan, bits[SAMPLE_W-1]);
            bits = bits << 1;                           // msb first
        end
    endtask

    task automatic send_frames(input stereo_frame_t frames[$]);
        @(negedge clk);
        send_word('0, CHAN_RIGHT, CHAN_LEFT);           // lead word so ws starts high
        foreach (frames[k])
        begin
            send_word(frames[k].left, CHAN_LEFT, CHAN_RIGHT);
            send_word(frames[k].right, CHAN_RIGHT, CHAN_LEFT);
        end
    endtask

endmodule

// File: rtl/i2si_rx_top.sv
module i2si_rx_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    i2si_en,
    input  logic                    sck,
    input  logic                    ws,
    input  logic                    sd,
    input  logic                    frame_rd,
    output logic                    frame_valid,
    output i2si_pkg::stereo_frame_t frame,
    output logic                    overflow
);

    import i2si_pkg::*;

    logic          sck_rise;                            // one cycle per sck rising edge
    logic          ws_s;
    logic          sd_s;
    logic          frame_wr;
    stereo_frame_t wr_frame;

    i2si_pin_sync i2si_pin_sync_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .sck      (sck),
        .ws       (ws),
        .sd       (sd),
        .sck_rise (sck_rise),
        .ws_s     (ws_s),
        .sd_s     (sd_s)
    );

    i2si_deserializer i2si_deserializer_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .i2si_en  (i2si_en),
        .sck_rise (sck_rise),
        .ws_s     (ws_s),
        .sd_s     (sd_s),
        .frame_wr (frame_wr),
        .wr_frame (wr_frame)
    );

    i2si_frame_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i2si_frame_fifo_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .i2si_en     (i2si_en),
        .wr_frame    (wr_frame),
        .frame_wr    (frame_wr),
        .frame_rd    (frame_rd),
        .frame       (frame),
        .frame_valid (frame_valid),
        .overflow    (overflow)
    );

endmodule

// File: rtl/i2si_frame_fifo.sv
module i2si_frame_fifo #(
    parameter int FIFO_DEPTH = 4                        // power of two, at least 2
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    i2si_en,
    input  i2si_pkg::stereo_frame_t wr_frame,
    input  logic                    frame_wr,
    input  logic                    frame_rd,
    output i2si_pkg::stereo_frame_t frame,
    output logic                    frame_valid,
    output logic                    overflow
);

    import i2si_pkg::*;

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    typedef logic [ADDR_W-1:0] ptr_t;                   // wraps at FIFO_DEPTH
    typedef logic [ADDR_W:0]   cnt_t;                   // 0 .. FIFO_DEPTH

    localparam cnt_t DEPTH_CNT = cnt_t'(FIFO_DEPTH);

    stereo_frame_t mem [FIFO_DEPTH];
    ptr_t          wr_ptr;
    ptr_t          rd_ptr;
    cnt_t          count;
    logic          full;
    logic          empty;
    logic          do_wr;
    logic          do_rd;

    assign full  = (count == DEPTH_CNT);
    assign empty = (count == '0);

    // nothing is stored while disabled, reads still drain old frames
    assign do_wr = frame_wr && i2si_en && !full;
    assign do_rd = frame_rd && !empty;                  // empty read ignored

    assign frame       = mem[rd_ptr];                   // head entry
    assign frame_valid = !empty;

    always_ff @(posedge clk)
    begin
        if (do_wr)
            mem[wr_ptr] <= wr_frame;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                // both or neither
            endcase
        end
    end

    // sticky until reception is disabled
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            overflow <= 1'b0;
        else if (!i2si_en)
            overflow <= 1'b0;
        else if (frame_wr && full)
            overflow <= 1'b1;                           // frame dropped
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        count <= DEPTH_CNT
    ) else $error("fifo count above FIFO_DEPTH");

endmodule

// File: rtl/i2si_deserializer.sv
module i2si_deserializer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  i2si_en,
    input  logic                  sck_rise,
    input  logic                  ws_s,
    input  logic                  sd_s,
    output logic                  frame_wr,
    output i2si_pkg::stereo_frame_t wr_frame
);

    import i2si_pkg::*;

    rx_state_t state;
    rx_state_t state_next;
    sample_t   shift_reg;                               // bits of the current word
    sample_t   shift_next;
    sample_t   left_hold;                               // last finished left word
    ws_chan_t  ws_cur;
    ws_chan_t  ws_prev;                                 // ws seen on previous sck edge
    logic      word_started;                            // a word boundary was seen
    logic      word_end;
    logic      left_end;
    logic      right_end;

    assign ws_cur     = ws_chan_t'(ws_s);
    assign shift_next = {shift_reg[SAMPLE_W-2:0], sd_s};

    // ws changes one bit early, so the bit on the changing edge is the LSB
    assign word_end  = sck_rise && (ws_cur != ws_prev);
    assign left_end  = word_end && (ws_prev == CHAN_LEFT);
    assign right_end = word_end && (ws_prev == CHAN_RIGHT);

    always_comb
    begin
        state_next = state;
        case (state)
            RX_IDLE:
            begin
                if (i2si_en)
                    state_next = RX_ALIGN;
            end
            RX_ALIGN:
            begin
                if (!i2si_en)
                    state_next = RX_IDLE;
                else if (left_end && word_started)
                    state_next = RX_RUN;                // first complete left word
            end
            RX_RUN:
            begin
                if (!i2si_en)
                    state_next = RX_IDLE;
            end
            default:
            begin
                state_next = RX_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state        <= RX_IDLE;
            ws_prev      <= CHAN_LEFT;
            word_started <= 1'b0;
            frame_wr     <= 1'b0;
        end
        else
        begin
            state    <= state_next;
            frame_wr <= (state == RX_RUN) && i2si_en && right_end;
            if (sck_rise)
                ws_prev <= ws_cur;                      // tracked even when idle
            if (state == RX_IDLE)
                word_started <= 1'b0;
            else if (word_end)
                word_started <= 1'b1;                   // next word starts clean
        end
    end

    always_ff @(posedge clk)
    begin
        if (sck_rise)
            shift_reg <= shift_next;
        if (left_end)
            left_hold <= shift_next;
        if (right_end)
        begin
            wr_frame.left  <= left_hold;
            wr_frame.right <= shift_next;               // includes the LSB just sampled
        end
    end

    // a written frame carries a latched left word and fully known bits
    a_wr_in_run: assert property (
        @(posedge clk) disable iff (!rst_n)
        frame_wr |-> (state == RX_RUN) && !$isunknown(wr_frame)
    ) else $error("frame_wr outside RX_RUN or with unknown frame bits");

endmodule

// File: rtl/i2si_pin_sync.sv
module i2si_pin_sync (
    input  logic clk,
    input  logic rst_n,
    input  logic sck,
    input  logic ws,
    input  logic sd,
    output logic sck_rise,
    output logic ws_s,
    output logic sd_s
);

    logic sck_meta;                                     // first stage
    logic sck_sync;                                     // second stage
    logic sck_prev;                                     // for edge compare
    logic ws_meta;
    logic ws_sync;
    logic sd_meta;
    logic sd_sync;

    // ws and sd get a third flop so they line up with the registered edge pulse
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sck_meta <= 1'b0;
            sck_sync <= 1'b0;
            sck_prev <= 1'b0;
            sck_rise <= 1'b0;
            ws_meta  <= 1'b0;
            ws_sync  <= 1'b0;
            ws_s     <= 1'b0;
            sd_meta  <= 1'b0;
            sd_sync  <= 1'b0;
            sd_s     <= 1'b0;
        end
        else
        begin
            sck_meta <= sck;
            sck_sync <= sck_meta;
            sck_prev <= sck_sync;
            sck_rise <= sck_sync & ~sck_prev;           // low to high seen
            ws_meta  <= ws;
            ws_sync  <= ws_meta;
            ws_s     <= ws_sync;                        // same age as sck_rise
            sd_meta  <= sd;
            sd_sync  <= sd_meta;
            sd_s     <= sd_sync;
        end
    end

    // each sck phase spans at least two clk cycles
    a_sck_phase: assert property (
        @(posedge clk) disable iff (!rst_n)
        (sck_sync != sck_prev) |=> (sck_sync == $past(sck_sync))
    ) else $error("sck phase shorter than two clk cycles");

endmodule

// File: rtl/i2si_pkg.sv
package i2si_pkg;

    // one channel word on the I2S wire
    localparam int SAMPLE_W = 16;

    // msb goes out first
    typedef logic [SAMPLE_W-1:0] sample_t;

    // left word in the upper half, right word in the lower half
    typedef struct packed {
        sample_t left;                                  // ws low word
        sample_t right;                                 // ws high word
    } stereo_frame_t;

    // channel as carried by the ws pin
    typedef enum logic {
        CHAN_LEFT  = 1'b0,                              // ws low
        CHAN_RIGHT = 1'b1                               // ws high
    } ws_chan_t;

    // deserializer FSM
    typedef enum logic [1:0] {
        RX_IDLE  = 2'd0,                                // reception disabled
        RX_ALIGN = 2'd1,                                // waiting for a full left word
        RX_RUN   = 2'd2                                 // frames are emitted
    } rx_state_t;

endpackage
